// ==== compile.f ====
design/threefishPkg.sv
design/injectQueue.sv
design/keyExtender.sv
design/tweakScheduler.sv
design/subkeyAdder.sv
design/keyInjectTop.sv
dv/keyInject_chk.sv
dv/keyInjectTb.sv

// ==== design/injectQueue.sv ====
`default_nettype none

// Input queue of the injection engine
// Items are written whenever the sender pushes one and popped when the output side has room
module injectQueue #(
	parameter int NumWords = 16,
	parameter int InDepth = 4
) (
	input wire clk,
	input wire rstN,
	input wire inValid,
	input wire [NumWords*threefishPkg::WordWidth-1:0] inState,
	input wire [NumWords*threefishPkg::WordWidth-1:0] inKey,
	input wire threefishPkg::wordT inTweak0,
	input wire threefishPkg::wordT inTweak1,
	input wire threefishPkg::subkeyIdxT inIdx,
	input wire issueOk,
	output logic inCredit,
	output logic issue,
	output logic [NumWords*threefishPkg::WordWidth-1:0] headState,
	output logic [NumWords*threefishPkg::WordWidth-1:0] headKey,
	output threefishPkg::wordT headTweak0,
	output threefishPkg::wordT headTweak1,
	output threefishPkg::subkeyIdxT headIdx
);

	localparam int StateWidth = NumWords * threefishPkg::WordWidth;
	// A depth of one still needs a one-bit pointer
	localparam int PtrWidth = (InDepth > 1) ? $clog2(InDepth) : 1;
	localparam int CntWidth = $clog2(InDepth + 1);

	logic [StateWidth-1:0] stateMem [InDepth];
	logic [StateWidth-1:0] keyMem [InDepth];
	threefishPkg::wordT tweak0Mem [InDepth];
	threefishPkg::wordT tweak1Mem [InDepth];
	threefishPkg::subkeyIdxT idxMem [InDepth];
	logic [PtrWidth-1:0] wrPtr;
	logic [PtrWidth-1:0] rdPtr;
	logic [CntWidth-1:0] count;

	// Pointers wrap at InDepth so that any depth works
	function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
		nextPtr = (ptr == PtrWidth'(InDepth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// The head leaves in any cycle where an output credit is free
	assign issue = (count != '0) && issueOk;

	// The head entry is shown straight from the buffer
	assign headState = stateMem[rdPtr];
	assign headKey = keyMem[rdPtr];
	assign headTweak0 = tweak0Mem[rdPtr];
	assign headTweak1 = tweak1Mem[rdPtr];
	assign headIdx = idxMem[rdPtr];

	// The sender only pushes while it holds a credit, so a push never finds the buffer full
	always_ff @(posedge clk)
	begin
		if (inValid)
		begin
			stateMem[wrPtr] <= inState;
			keyMem[wrPtr] <= inKey;
			tweak0Mem[wrPtr] <= inTweak0;
			tweak1Mem[wrPtr] <= inTweak1;
			idxMem[wrPtr] <= inIdx;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			inCredit <= 1'b0;
		end
		else
		begin
			// Each pop hands one credit back to the sender a cycle later
			inCredit <= issue;
			if (inValid)
				wrPtr <= nextPtr(wrPtr);
			if (issue)
				rdPtr <= nextPtr(rdPtr);
			// A push and a pop together leave the occupancy as it is
			case ({inValid, issue})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/keyExtender.sv ====
`default_nettype none

// Key side of the subkey schedule
// Extends the key with its parity word and picks the rotated subkey words
module keyExtender #(
	parameter int NumWords = 16
) (
	input wire clk,
	input wire rstN,
	input wire issue,
	input wire [NumWords*threefishPkg::WordWidth-1:0] headKey,
	input wire threefishPkg::subkeyIdxT headIdx,
	input wire [NumWords*threefishPkg::WordWidth-1:0] headState,
	output logic stageValid,
	output logic [NumWords*threefishPkg::WordWidth-1:0] keyAddend,
	output logic [NumWords*threefishPkg::WordWidth-1:0] stageState
);

	localparam int W = threefishPkg::WordWidth;

	// Extended key holds the N key words followed by the parity word
	threefishPkg::wordT extKey [NumWords+1];
	threefishPkg::wordT parity;
	logic [NumWords*W-1:0] subkey;

	always_comb
	begin
		parity = threefishPkg::KeyParity;
		for (int w = 0; w < NumWords; w++)
		begin
			extKey[w] = headKey[w*W +: W];
			parity = parity ^ headKey[w*W +: W];
		end
		extKey[NumWords] = parity;
		// Subkey s word i is extended word (s + i) mod (N + 1)
		// The rotation wraps over the parity word for larger s
		for (int i = 0; i < NumWords; i++)
		begin
			subkey[i*W +: W] = extKey[(int'(headIdx) + i) % (NumWords + 1)];
		end
	end

	// Only the valid bit is control state
	always_ff @(posedge clk)
	begin
		if (!rstN)
			stageValid <= 1'b0;
		else
			stageValid <= issue;
	end

	// The state rides along with the subkey so both reach the adder together
	always_ff @(posedge clk)
	begin
		keyAddend <= subkey;
		stageState <= headState;
	end

endmodule

`default_nettype wire

// ==== design/keyInjectTop.sv ====
`default_nettype none

// Threefish subkey injection engine
// Credit flow control on both sides, two cycles from issue to output
module keyInjectTop #(
	parameter int NumWords = 16,
	parameter int InDepth = 4,
	parameter int OutCredits = 2
) (
	input wire clk,
	input wire rstN,
	input wire inValid,
	input wire [NumWords*threefishPkg::WordWidth-1:0] inState,
	input wire [NumWords*threefishPkg::WordWidth-1:0] inKey,
	input wire threefishPkg::wordT inTweak0,
	input wire threefishPkg::wordT inTweak1,
	input wire threefishPkg::subkeyIdxT inIdx,
	output logic inCredit,
	output logic outValid,
	output logic [NumWords*threefishPkg::WordWidth-1:0] outState,
	input wire outCredit
);

	localparam int StateWidth = NumWords * threefishPkg::WordWidth;

	logic issue;
	logic issueOk;
	logic [StateWidth-1:0] headState;
	logic [StateWidth-1:0] headKey;
	threefishPkg::wordT headTweak0;
	threefishPkg::wordT headTweak1;
	threefishPkg::subkeyIdxT headIdx;
	logic stageValid;
	logic [StateWidth-1:0] keyAddend;
	logic [StateWidth-1:0] stageState;
	threefishPkg::wordT tweakAddA;
	threefishPkg::wordT tweakAddB;
	threefishPkg::wordT idxAdd;

	injectQueue #(.NumWords(NumWords), .InDepth(InDepth)) i_injectQueue (
		.clk(clk), .rstN(rstN), .inValid(inValid), .inState(inState), .inKey(inKey),
		.inTweak0(inTweak0), .inTweak1(inTweak1), .inIdx(inIdx), .issueOk(issueOk),
		.inCredit(inCredit), .issue(issue), .headState(headState), .headKey(headKey),
		.headTweak0(headTweak0), .headTweak1(headTweak1), .headIdx(headIdx)
	);

	// Key side and tweak side work in parallel on the issued head
	keyExtender #(.NumWords(NumWords)) i_keyExtender (
		.clk(clk), .rstN(rstN), .issue(issue), .headKey(headKey), .headIdx(headIdx),
		.headState(headState), .stageValid(stageValid), .keyAddend(keyAddend),
		.stageState(stageState)
	);

	tweakScheduler i_tweakScheduler (
		.clk(clk), .headTweak0(headTweak0), .headTweak1(headTweak1), .headIdx(headIdx),
		.tweakAddA(tweakAddA), .tweakAddB(tweakAddB), .idxAdd(idxAdd)
	);

	subkeyAdder #(.NumWords(NumWords), .OutCredits(OutCredits)) i_subkeyAdder (
		.clk(clk), .rstN(rstN), .stageValid(stageValid), .stageState(stageState),
		.keyAddend(keyAddend), .tweakAddA(tweakAddA), .tweakAddB(tweakAddB),
		.idxAdd(idxAdd), .issue(issue), .outCredit(outCredit), .outValid(outValid),
		.outState(outState), .issueOk(issueOk)
	);

endmodule

`default_nettype wire

// ==== design/subkeyAdder.sv ====
`default_nettype none

// Final stage of the injection
// Adds the subkey to the state and keeps track of free slots at the receiver
module subkeyAdder #(
	parameter int NumWords = 16,
	parameter int OutCredits = 2
) (
	input wire clk,
	input wire rstN,
	input wire stageValid,
	input wire [NumWords*threefishPkg::WordWidth-1:0] stageState,
	input wire [NumWords*threefishPkg::WordWidth-1:0] keyAddend,
	input wire threefishPkg::wordT tweakAddA,
	input wire threefishPkg::wordT tweakAddB,
	input wire threefishPkg::wordT idxAdd,
	input wire issue,
	input wire outCredit,
	output logic outValid,
	output logic [NumWords*threefishPkg::WordWidth-1:0] outState,
	output logic issueOk
);

	localparam int W = threefishPkg::WordWidth;
	localparam int CntWidth = $clog2(OutCredits + 1);

	logic [NumWords*W-1:0] sumState;
	logic [CntWidth-1:0] creditCnt;

	// Every word gets its subkey word, all sums wrap modulo 2^64
	always_comb
	begin
		for (int w = 0; w < NumWords; w++)
		begin
			sumState[w*W +: W] = stageState[w*W +: W] + keyAddend[w*W +: W];
		end
		// The top three words also take the tweak words and the index
		sumState[(NumWords-3)*W +: W] = sumState[(NumWords-3)*W +: W] + tweakAddA;
		sumState[(NumWords-2)*W +: W] = sumState[(NumWords-2)*W +: W] + tweakAddB;
		sumState[(NumWords-1)*W +: W] = sumState[(NumWords-1)*W +: W] + idxAdd;
	end

	// The count is taken at issue, so items still in the pipe already hold a slot
	assign issueOk = (creditCnt != '0);

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			outValid <= 1'b0;
			creditCnt <= CntWidth'(OutCredits);
		end
		else
		begin
			outValid <= stageValid;
			// An issue and a returned credit in one cycle cancel out
			case ({issue, outCredit})
				2'b10: creditCnt <= creditCnt - 1'b1;
				2'b01: creditCnt <= creditCnt + 1'b1;
				default: creditCnt <= creditCnt;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		outState <= sumState;
	end

endmodule

`default_nettype wire

// ==== design/threefishPkg.sv ====
`default_nettype none

// Shared Threefish definitions for the subkey injection engine
package threefishPkg;

	// Threefish works on 64-bit words throughout
	localparam int WordWidth = 64;

	// One cipher word of state, key or tweak
	typedef logic [WordWidth-1:0] wordT;

	// The key schedule parity constant
	// XORed with every key word it gives the extra key word N
	localparam wordT KeyParity = 64'h5555_5555_5555_5555;

	// Threefish-1024 uses subkeys 0 through 20
	// Five bits hold every index of that range
	localparam int SubkeyIdxWidth = 5;

	// The subkey index s of one injection
	typedef logic [SubkeyIdxWidth-1:0] subkeyIdxT;

endpackage

`default_nettype wire

// ==== design/tweakScheduler.sv ====
`default_nettype none

// Tweak side of the subkey schedule
// Produces the three addends for the top three state words
module tweakScheduler (
	input wire clk,
	input wire threefishPkg::wordT headTweak0,
	input wire threefishPkg::wordT headTweak1,
	input wire threefishPkg::subkeyIdxT headIdx,
	output threefishPkg::wordT tweakAddA,
	output threefishPkg::wordT tweakAddB,
	output threefishPkg::wordT idxAdd
);

	localparam int PadWidth = threefishPkg::WordWidth - threefishPkg::SubkeyIdxWidth;

	threefishPkg::wordT tweak2;
	threefishPkg::wordT selA;
	threefishPkg::wordT selB;
	logic [1:0] idxMod3;

	// The third tweak word is the XOR of the other two
	assign tweak2 = headTweak0 ^ headTweak1;
	assign idxMod3 = 2'(headIdx % 5'd3);

	// Word N-3 takes t(s mod 3) and word N-2 takes t((s+1) mod 3)
	always_comb
	begin
		case (idxMod3)
			2'd0:
			begin
				selA = headTweak0;
				selB = headTweak1;
			end
			2'd1:
			begin
				selA = headTweak1;
				selB = tweak2;
			end
			default:
			begin
				selA = tweak2;
				selB = headTweak0;
			end
		endcase
	end

	// Registered in the same cycle as the key side so both line up at the adder
	always_ff @(posedge clk)
	begin
		tweakAddA <= selA;
		tweakAddB <= selB;
		idxAdd <= {{PadWidth{1'b0}}, headIdx};
	end

endmodule

`default_nettype wire

// ==== dv/keyInjectTb.sv ====
`default_nettype none

// Testbench for the subkey injection engine
module keyInjectTb;

	localparam int NumWords = 16;
	localparam int StateW = NumWords * 64;
	localparam int InDepth = 4;
	localparam int OutCredits = 2;
	localparam int Timeout = 200;

	logic clk = 1'b0;
	logic rstN;
	logic inValid;
	logic [StateW-1:0] inState;
	logic [StateW-1:0] inKey;
	logic [63:0] inTweak0;
	logic [63:0] inTweak1;
	logic [4:0] inIdx;
	logic inCredit;
	logic outValid;
	logic [StateW-1:0] outState;
	logic outCredit = 1'b0;

	int seed = 32'h4758;
	int errors = 0;
	int rxErrors = 0;
	int rxChecks = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int sentCount = 0;
	int creditsBack = 0;
	int rxCount = 0;
	int cycleNum = 0;
	int creditDelay = 0;
	bit holdCredits = 1'b0;
	bit creditDue = 1'b0;
	// Expected results in send order, and the cycles at which receiver slots free up
	logic [StateW-1:0] expQ [$];
	int returnQ [$];
	logic [StateW-1:0] expState;
	logic [StateW-1:0] testKey;
	int startErr;
	int rxStart;
	int sentStart;
	int backMid;

	always #4 clk = ~clk;

	keyInjectTop #(.NumWords(NumWords), .InDepth(InDepth), .OutCredits(OutCredits)) i_dut (
		.clk(clk), .rstN(rstN), .inValid(inValid), .inState(inState), .inKey(inKey),
		.inTweak0(inTweak0), .inTweak1(inTweak1), .inIdx(inIdx), .inCredit(inCredit),
		.outValid(outValid), .outState(outState), .outCredit(outCredit)
	);

	// Builds subkey s from the extended key and tweaks, then adds it to the state
	function automatic logic [StateW-1:0] injectRef(input logic [StateW-1:0] st,
		input logic [StateW-1:0] key, input logic [63:0] t0, input logic [63:0] t1,
		input logic [4:0] s);
		logic [63:0] ext [NumWords+1];
		logic [63:0] tw [3];
		logic [63:0] sub;
		logic [StateW-1:0] res;
		ext[NumWords] = 64'h5555555555555555;
		for (int i = 0; i < NumWords; i++)
		begin
			ext[i] = key[i*64 +: 64];
			ext[NumWords] ^= key[i*64 +: 64];
		end
		tw[0] = t0;
		tw[1] = t1;
		tw[2] = t0 ^ t1;
		for (int i = 0; i < NumWords; i++)
		begin
			sub = ext[(int'(s) + i) % (NumWords + 1)];
			if (i == NumWords - 3)
				sub += tw[int'(s) % 3];
			else if (i == NumWords - 2)
				sub += tw[(int'(s) + 1) % 3];
			else if (i == NumWords - 1)
				sub += 64'(s);
			res[i*64 +: 64] = st[i*64 +: 64] + sub;
		end
		return res;
	endfunction

	function automatic logic [StateW-1:0] randomWide();
		logic [StateW-1:0] r;
		for (int i = 0; i < StateW / 32; i++)
			r[i*32 +: 32] = $random(seed);
		return r;
	endfunction

	// Credits the upstream still holds
	function automatic int creditsFree();
		return InDepth + creditsBack - sentCount;
	endfunction

	function automatic int totalErrors();
		return errors + rxErrors;
	endfunction

	task automatic failTimeout(input string what);
		$display("timeout waiting for %s at %0t", what, $time);
		$display("ERRORS FOUND");
		$finish;
	endtask

	// Waits for a credit, then holds inValid for exactly one cycle
	task automatic sendItem(input logic [StateW-1:0] st, input logic [StateW-1:0] key,
		input logic [63:0] t0, input logic [63:0] t1, input logic [4:0] s);
		int waited;
		waited = 0;
		while (creditsFree() == 0)
		begin
			@(negedge clk);
			waited++;
			if (waited > Timeout)
				failTimeout("an input credit");
		end
		inState = st;
		inKey = key;
		inTweak0 = t0;
		inTweak1 = t1;
		inIdx = s;
		inValid = 1'b1;
		sentCount++;
		expQ.push_back(injectRef(st, key, t0, t1, s));
		@(negedge clk);
		inValid = 1'b0;
	endtask

	task automatic sendRandom(input logic [4:0] s);
		sendItem(randomWide(), randomWide(), {$random(seed), $random(seed)},
			{$random(seed), $random(seed)}, s);
	endtask

	// Done once every result has arrived and every receiver slot has been returned
	task automatic waitIdle();
		int waited;
		waited = 0;
		while (expQ.size() != 0 || returnQ.size() != 0 || outCredit)
		begin
			@(negedge clk);
			waited++;
			if (waited > Timeout)
				failTimeout("outValid");
		end
		repeat (2) @(negedge clk);
	endtask

	task automatic endTest(input string name, input int errBefore);
		testsRun++;
		if (totalErrors() > errBefore)
		begin
			testsFailed++;
			$display("test %s: FAIL with %0d errors", name, totalErrors() - errBefore);
		end
		else
			$display("test %s: ok", name);
	endtask

	// Compares outputs in order and models the receiver slots
	always @(posedge clk)
	begin
		if (rstN && inCredit)
			creditsBack++;
		if (rstN && outValid)
		begin
			rxCount++;
			returnQ.push_back(cycleNum + creditDelay);
			if (expQ.size() == 0)
			begin
				rxErrors++;
				$display("outValid at %0t with no item outstanding", $time);
			end
			else
			begin
				expState = expQ.pop_front();
				rxChecks++;
				if (outState !== expState)
				begin
					rxErrors++;
					$display("MISMATCH at %0t: outState expected %h actual %h",
						$time, expState, outState);
				end
			end
		end
		creditDue = rstN && !holdCredits && returnQ.size() > 0 && returnQ[0] <= cycleNum;
		if (creditDue)
			void'(returnQ.pop_front());
		cycleNum++;
	end

	// One credit pulse per freed slot, driven away from the rising edge
	always @(negedge clk)
		outCredit = creditDue;

	initial
	begin
		rstN = 1'b0;
		inValid = 1'b0;
		inState = '0;
		inKey = '0;
		inTweak0 = '0;
		inTweak1 = '0;
		inIdx = '0;
		repeat (2) @(negedge clk);
		rstN = 1'b1;

		// Nothing may move while the engine is idle
		startErr = totalErrors();
		for (int c = 0; c < 10; c++)
		begin
			@(negedge clk);
			if (outValid !== 1'b0)
			begin
				errors++;
				$display("MISMATCH at %0t: outValid expected 0 actual %b", $time, outValid);
			end
			if (inCredit !== 1'b0)
			begin
				errors++;
				$display("MISMATCH at %0t: inCredit expected 0 actual %b", $time, inCredit);
			end
		end
		endTest("idle after reset", startErr);

		// With everything else zero, subkey 0 is just the key
		startErr = totalErrors();
		testKey = randomWide();
		if (injectRef('0, testKey, '0, '0, '0) !== testKey)
		begin
			errors++;
			$display("reference model does not return the key for subkey 0");
		end
		sendItem('0, testKey, '0, '0, '0);
		waitIdle();
		endTest("zero state subkey 0", startErr);

		// Every subkey index once, which covers all rotation wraps and tweak phases
		startErr = totalErrors();
		creditDelay = 3;
		for (int s = 0; s <= 20; s++)
			sendRandom(5'(s));
		waitIdle();
		endTest("all subkey indices", startErr);

		startErr = totalErrors();
		creditDelay = 0;
		rxStart = rxCount;
		for (int n = 0; n < 12; n++)
			sendRandom(5'($unsigned($random(seed)) % 21));
		waitIdle();
		if (rxCount - rxStart != 12)
		begin
			errors++;
			$display("expected 12 outputs in the back-to-back run but saw %0d", rxCount - rxStart);
		end
		endTest("back to back", startErr);

		// The receiver keeps its slots, so the pipe, the queue and the sender all stall
		startErr = totalErrors();
		holdCredits = 1'b1;
		rxStart = rxCount;
		sentStart = sentCount;
		backMid = creditsBack;
		for (int c = 0; c < 40; c++)
		begin
			if (c == 20)
				backMid = creditsBack;
			if (creditsFree() > 0)
				sendRandom(5'(sentCount % 21));
			else
				@(negedge clk);
		end
		if (rxCount - rxStart > OutCredits)
		begin
			errors++;
			$display("%0d outputs appeared while credits were withheld", rxCount - rxStart);
		end
		if (creditsBack != backMid)
		begin
			errors++;
			$display("input credits kept coming back while the output was blocked");
		end
		if (creditsFree() != 0)
		begin
			errors++;
			$display("upstream still held input credits after the stall");
		end
		holdCredits = 1'b0;
		for (int n = 0; n < 4; n++)
			sendRandom(5'(sentCount % 21));
		waitIdle();
		if (rxCount - rxStart != sentCount - sentStart)
		begin
			errors++;
			$display("sent %0d items but %0d came out", sentCount - sentStart, rxCount - rxStart);
		end
		if (creditsBack != sentCount)
		begin
			errors++;
			$display("%0d input credits returned for %0d items", creditsBack, sentCount);
		end
		endTest("output back-pressure", startErr);

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			testsRun, testsFailed, rxChecks, totalErrors());
		if (totalErrors() == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/keyInject_chk.sv ====
`default_nettype none

// Range checks for a counter that rises and falls with traffic
// One copy watches the output credit count, another the input queue occupancy
module keyInjectChk #(
	parameter int LevelWidth = 3,
	parameter int MaxLevel = 4
) (
	input wire clk,
	input wire rstN,
	input wire [LevelWidth-1:0] level,
	input wire drain,
	input wire fill
);

	// The counter never goes past its ceiling
	levelInRange: assert property (@(posedge clk) disable iff (!rstN)
		level <= LevelWidth'(MaxLevel))
		else $error("level %0d above its maximum %0d", level, MaxLevel);

	// Nothing is taken from an empty counter
	noDrainAtZero: assert property (@(posedge clk) disable iff (!rstN)
		drain |-> level != '0)
		else $error("drain seen while the level is zero");

	// Nothing is added to a full one
	noFillAtMax: assert property (@(posedge clk) disable iff (!rstN)
		fill |-> level != LevelWidth'(MaxLevel))
		else $error("fill seen while the level is at its maximum");

endmodule

// Every issue spends an output credit and the receiver only returns credits it holds
bind subkeyAdder keyInjectChk #(.LevelWidth(CntWidth), .MaxLevel(OutCredits)) i_creditChk (
	.clk(clk), .rstN(rstN), .level(creditCnt), .drain(issue), .fill(outCredit)
);

// Pops need an item, and a push must never find the queue full
bind injectQueue keyInjectChk #(.LevelWidth(CntWidth), .MaxLevel(InDepth)) i_queueChk (
	.clk(clk), .rstN(rstN), .level(count), .drain(issue), .fill(inValid)
);

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and decide the result from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module keyInjectTb -f compile.f \
	&& ./obj_dir/VkeyInjectTb | tee sim.log \
	&& grep -q "^NO ERRORS$" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
